// File: hdl/gamePkg.sv
// Shared types and constants for the sprite game core
// Coordinates, keycodes, facing, layers, sprite sizes and attack offsets
package gamePkg;

    typedef logic [8:0]  coordT;       // Pixel coordinate on screen or in a sprite
    typedef logic [7:0]  keycodeT;     // HID keycode
    typedef logic [1:0]  dirT;         // Facing code
    typedef logic [10:0] spriteAddrT;  // Up to 32x48 sprite image

    typedef enum logic [1:0] {
        layerBg     = 2'd0,
        layerPlayer = 2'd1,
        layerAttack = 2'd2
    } layerT;

    // One sprite's result for the current pixel
    typedef struct packed {
        logic       hit;
        spriteAddrT addr;
    } spriteHitT;

    localparam coordT ScreenW = 9'd320;
    localparam coordT ScreenH = 9'd240;

    localparam coordT PlayerW = 9'd32;
    localparam coordT PlayerH = 9'd48;

    localparam keycodeT KeyW     = 8'd26;
    localparam keycodeT KeyA     = 8'd4;
    localparam keycodeT KeyS     = 8'd22;
    localparam keycodeT KeyD     = 8'd7;
    localparam keycodeT KeySpace = 8'd44;

    localparam dirT DirDown  = 2'd0;
    localparam dirT DirLeft  = 2'd1;
    localparam dirT DirUp    = 2'd2;
    localparam dirT DirRight = 2'd3;

    // Roughly screen centre
    localparam coordT StartX = 9'd144;
    localparam coordT StartY = 9'd96;

    // Attack origin relative to the player, indexed by facing
    localparam coordT AttackOffX [4] = '{9'd2, 9'd0, 9'd36, 9'd36};
    localparam coordT AttackOffY [4] = '{9'd40, 9'd10, 9'd2, 9'd30};

endpackage

// File: hdl/frameTick.sv
// Frame strobe edge detector and movement tick divider
`timescale 1ns/1ns

module frameTick #(
    parameter int FrameDiv = 4
) (
    input  logic Clk,
    input  logic rstN,
    input  logic frameClk,
    output logic moveTick
);

    localparam int CntW = (FrameDiv > 1) ? $clog2(FrameDiv) : 1;
    localparam logic [CntW-1:0] LastCnt = CntW'(FrameDiv - 1);

    logic            frameSync;   // Sampling register
    logic            frameSyncD;
    logic            frameEdge;   // One cycle per frame
    logic [CntW-1:0] edgeCnt;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            frameSync  <= 1'b0;
            frameSyncD <= 1'b0;
            frameEdge  <= 1'b0;
        end else begin
            frameSync  <= frameClk;
            frameSyncD <= frameSync;
            frameEdge  <= frameSync & ~frameSyncD;
        end
    end

    // Every FrameDiv-th edge gives a tick
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            edgeCnt  <= '0;
            moveTick <= 1'b0;
        end else begin
            moveTick <= 1'b0;
            if (frameEdge) begin
                if (edgeCnt == LastCnt) begin
                    edgeCnt  <= '0;
                    moveTick <= 1'b1;
                end else begin
                    edgeCnt <= edgeCnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/playerMotion.sv
// Player position and facing, stepped by held keys on each movement tick
// Position is clamped so the sprite stays on screen
`timescale 1ns/1ns

module playerMotion #(
    parameter int Step = 1
) (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             moveTick,
    input  gamePkg::keycodeT keycode,
    output gamePkg::coordT   playerX,
    output gamePkg::coordT   playerY,
    output gamePkg::dirT     playerDir
);
    import gamePkg::*;

    localparam coordT MaxX  = ScreenW - PlayerW;  // Rightmost sprite origin
    localparam coordT MaxY  = ScreenH - PlayerH;
    localparam coordT StepC = coordT'(Step);

    coordT nextX;
    coordT nextY;
    dirT   nextDir;

    // Move toward 0, stopping at the edge
    function automatic coordT stepLow(coordT pos);
        if (pos < StepC) begin
            return '0;
        end
        return pos - StepC;
    endfunction

    // Move toward limit without wrapping past it
    function automatic coordT stepHigh(coordT pos, coordT limit);
        if ((pos >= limit) || ((limit - pos) < StepC)) begin
            return limit;
        end
        return pos + StepC;
    endfunction

    always_comb begin
        nextX   = playerX;
        nextY   = playerY;
        nextDir = playerDir;
        case (keycode)
            KeyW: begin
                nextY   = stepLow(playerY);
                nextDir = DirUp;
            end
            KeyA: begin
                nextX   = stepLow(playerX);
                nextDir = DirLeft;
            end
            KeyS: begin
                nextY   = stepHigh(playerY, MaxY);
                nextDir = DirDown;
            end
            KeyD: begin
                nextX   = stepHigh(playerX, MaxX);
                nextDir = DirRight;
            end
            default: ;  // Other keys leave the player still
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            playerX   <= StartX;
            playerY   <= StartY;
            playerDir <= DirDown;
        end else if (moveTick) begin
            playerX   <= nextX;
            playerY   <= nextY;
            playerDir <= nextDir;
        end
    end

endmodule

// File: hdl/attackSprite.sv
// Attack sprite: show flag from the space key, placement from facing,
// and per-pixel hit test with row-major address
`timescale 1ns/1ns

module attackSprite #(
    parameter int AttackW = 16,
    parameter int AttackH = 16
) (
    input  logic               Clk,
    input  logic               rstN,
    input  gamePkg::keycodeT   keycode,
    input  gamePkg::coordT     playerX,
    input  gamePkg::coordT     playerY,
    input  gamePkg::dirT       playerDir,
    input  gamePkg::coordT     pixelX,
    input  gamePkg::coordT     pixelY,
    output gamePkg::spriteHitT attackHit
);
    import gamePkg::*;

    localparam coordT WidthC  = coordT'(AttackW);
    localparam coordT HeightC = coordT'(AttackH);

    logic  showAttack;  // Space held, one clock late
    coordT originX;
    coordT originY;
    coordT distX;
    coordT distY;
    logic  inBox;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            showAttack <= 1'b0;
        end else begin
            showAttack <= (keycode == KeySpace);
        end
    end

    // Origin follows the player every cycle
    always_comb begin
        originX = playerX + AttackOffX[playerDir];
        originY = playerY + AttackOffY[playerDir];
    end

    assign distX = pixelX - originX;
    assign distY = pixelY - originY;

    assign inBox = (pixelX >= originX) && (pixelX < originX + WidthC) &&
                   (pixelY >= originY) && (pixelY < originY + HeightC);

    always_comb begin
        attackHit = '0;
        if (showAttack && inBox) begin
            attackHit.hit  = 1'b1;
            attackHit.addr = spriteAddrT'(distX) +
                             spriteAddrT'(distY) * spriteAddrT'(WidthC);
        end
    end

endmodule

// File: hdl/spriteMixer.sv
// Player hit test and layer priority, with registered layer and address
`timescale 1ns/1ns

module spriteMixer (
    input  logic               Clk,
    input  logic               rstN,
    input  gamePkg::coordT     pixelX,
    input  gamePkg::coordT     pixelY,
    input  gamePkg::coordT     playerX,
    input  gamePkg::coordT     playerY,
    input  gamePkg::spriteHitT attackHit,
    output gamePkg::layerT     layer,
    output gamePkg::spriteAddrT spriteAddr
);
    import gamePkg::*;

    coordT      distX;
    coordT      distY;
    logic       playerHit;
    spriteAddrT playerAddr;
    layerT      nextLayer;
    spriteAddrT nextAddr;

    assign distX = pixelX - playerX;
    assign distY = pixelY - playerY;

    assign playerHit = (pixelX >= playerX) && (pixelX < playerX + PlayerW) &&
                       (pixelY >= playerY) && (pixelY < playerY + PlayerH);

    // Row-major within the 32-wide player image
    assign playerAddr = spriteAddrT'(distX) + spriteAddrT'(distY) * spriteAddrT'(PlayerW);

    // Attack sits above the player
    always_comb begin
        if (attackHit.hit) begin
            nextLayer = layerAttack;
            nextAddr  = attackHit.addr;
        end else if (playerHit) begin
            nextLayer = layerPlayer;
            nextAddr  = playerAddr;
        end else begin
            nextLayer = layerBg;
            nextAddr  = '0;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            layer      <= layerBg;
            spriteAddr <= '0;
        end else begin
            layer      <= nextLayer;
            spriteAddr <= nextAddr;
        end
    end

endmodule

// File: hdl/gameCore.sv
// Sprite game core top level
// Movement tick, player motion, attack sprite and layer mixer
`timescale 1ns/1ns

module gameCore #(
    parameter int FrameDiv = 4,
    parameter int Step     = 1,
    parameter int AttackW  = 16,
    parameter int AttackH  = 16
) (
    input  logic                Clk,
    input  logic                rstN,
    input  logic                frameClk,    // ~60 Hz, unrelated phase
    input  gamePkg::keycodeT    keycode,
    input  gamePkg::coordT      pixelX,
    input  gamePkg::coordT      pixelY,
    output gamePkg::layerT      layer,
    output gamePkg::spriteAddrT spriteAddr,
    output gamePkg::coordT      playerX,
    output gamePkg::coordT      playerY,
    output gamePkg::dirT        playerDir
);
    import gamePkg::*;

    logic      moveTick;
    spriteHitT attackHit;

    frameTick #(
        .FrameDiv (FrameDiv)
    ) frameTick_inst (
        .Clk      (Clk),
        .rstN     (rstN),
        .frameClk (frameClk),
        .moveTick (moveTick)
    );

    playerMotion #(
        .Step (Step)
    ) playerMotion_inst (
        .Clk       (Clk),
        .rstN      (rstN),
        .moveTick  (moveTick),
        .keycode   (keycode),
        .playerX   (playerX),
        .playerY   (playerY),
        .playerDir (playerDir)
    );

    attackSprite #(
        .AttackW (AttackW),
        .AttackH (AttackH)
    ) attackSprite_inst (
        .Clk       (Clk),
        .rstN      (rstN),
        .keycode   (keycode),
        .playerX   (playerX),
        .playerY   (playerY),
        .playerDir (playerDir),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .attackHit (attackHit)
    );

    spriteMixer spriteMixer_inst (
        .Clk        (Clk),
        .rstN       (rstN),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .playerX    (playerX),
        .playerY    (playerY),
        .attackHit  (attackHit),
        .layer      (layer),
        .spriteAddr (spriteAddr)
    );

endmodule

// File: verif/gameCore_checker.sv
// Assertions on the game core: tick width, position bounds, layer and address
`timescale 1ns/1ns

module gameCore_checker (
    input logic                Clk,
    input logic                rstN,
    input logic                moveTick,
    input gamePkg::coordT      playerX,
    input gamePkg::coordT      playerY,
    input gamePkg::layerT      layer,
    input gamePkg::spriteAddrT spriteAddr
);
    import gamePkg::*;

    tickOnePulse: assert property (@(posedge Clk) disable iff (!rstN)
        moveTick |=> !moveTick)
        else $error("moveTick lasted more than one cycle");

    // Sprite origin never leaves the screen
    posInBounds: assert property (@(posedge Clk) disable iff (!rstN)
        (playerX <= ScreenW - PlayerW) && (playerY <= ScreenH - PlayerH))
        else $error("player position outside the screen");

    bgAddrZero: assert property (@(posedge Clk) disable iff (!rstN)
        (layer == layerBg) |-> (spriteAddr == '0))
        else $error("background pixel with a nonzero sprite address");

endmodule

bind gameCore gameCore_checker gameCore_checker_inst (
    .Clk        (Clk),
    .rstN       (rstN),
    .moveTick   (moveTick),
    .playerX    (playerX),
    .playerY    (playerY),
    .layer      (layer),
    .spriteAddr (spriteAddr)
);

// File: verif/gameCoreTb.sv
// Testbench for the sprite game core
// Reference model, compare tasks, frame and pixel stimulus, watchdog
`timescale 1ns/1ns

module gameCoreTb;
    import gamePkg::*;

    localparam int FrameDiv    = 3;
    localparam int Step        = 5;     // Not a divisor of the limits, so clamping shows
    localparam int AttackW     = 16;
    localparam int AttackH     = 16;
    localparam int ClkPeriod   = 8;
    localparam int FrameHigh   = 10;    // Clocks with frameClk high
    localparam int FrameLow    = 10;
    localparam int TickLag     = 3;     // Clocks from frameClk rise to moveTick
    localparam int MoveFrames  = 7;
    localparam int ClampFrames = 200;   // Enough to cross the whole screen
    localparam int TotalFrames = 4 * MoveFrames + 5 * FrameDiv + 4 * ClampFrames;
    localparam int TimeoutNs   = TotalFrames * (FrameHigh + FrameLow) * ClkPeriod + 40000;
    localparam int MaxX        = int'(ScreenW) - int'(PlayerW);
    localparam int MaxY        = int'(ScreenH) - int'(PlayerH);
    localparam int AttackDx [4] = '{2, 0, 36, 36};   // Down, left, up, right
    localparam int AttackDy [4] = '{40, 10, 2, 30};

    typedef struct packed {
        coordT x;
        coordT y;
        dirT   dir;
    } posT;

    typedef struct packed {
        layerT      layer;
        spriteAddrT addr;
    } pixResT;

    logic       Clk;
    logic       rstN;
    logic       frameClk;
    keycodeT    keycode;
    coordT      pixelX;
    coordT      pixelY;
    layerT      layer;
    spriteAddrT spriteAddr;
    coordT      playerX;
    coordT      playerY;
    dirT        playerDir;

    posT    expPos;       // Model position and facing
    logic   expShow;      // Model of the space flag
    int     edgeCount;
    int     checkCount;
    pixResT stageRes;     // Expected for the pixel now on the inputs
    logic   stageValid;
    string  stageName;
    pixResT expRes;       // Same, one clock later
    logic   expValid;
    string  expName;

    gameCore #(
        .FrameDiv (FrameDiv),
        .Step     (Step),
        .AttackW  (AttackW),
        .AttackH  (AttackH)
    ) gameCore_inst (.*);

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    // Position and facing after one tick with key held
    function automatic posT nextPos(posT cur, keycodeT key);
        posT nxt;
        int  x;
        int  y;
        nxt = cur;
        x   = int'(cur.x);
        y   = int'(cur.y);
        case (key)
            KeyD: begin
                x       = (x + Step > MaxX) ? MaxX : x + Step;
                nxt.dir = DirRight;
            end
            KeyA: begin
                x       = (x < Step) ? 0 : x - Step;
                nxt.dir = DirLeft;
            end
            KeyW: begin
                y       = (y < Step) ? 0 : y - Step;
                nxt.dir = DirUp;
            end
            KeyS: begin
                y       = (y + Step > MaxY) ? MaxY : y + Step;
                nxt.dir = DirDown;
            end
            default: ;
        endcase
        nxt.x = coordT'(x);
        nxt.y = coordT'(y);
        return nxt;
    endfunction

    // Layer and address for one pixel, attack above player above background
    function automatic pixResT refPixel(int px, int py, posT pos, logic show);
        pixResT res;
        int     x;
        int     y;
        int     ax;
        int     ay;
        x         = int'(pos.x);
        y         = int'(pos.y);
        ax        = x + AttackDx[pos.dir];
        ay        = y + AttackDy[pos.dir];
        res.layer = layerBg;
        res.addr  = '0;
        if (show && px >= ax && px < ax + AttackW && py >= ay && py < ay + AttackH) begin
            res.layer = layerAttack;
            res.addr  = spriteAddrT'((px - ax) + (py - ay) * AttackW);
        end else if (px >= x && px < x + int'(PlayerW) && py >= y && py < y + int'(PlayerH)) begin
            res.layer = layerPlayer;
            res.addr  = spriteAddrT'((px - x) + (py - y) * int'(PlayerW));
        end
        return res;
    endfunction

    task automatic abortRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at first failure");
    endtask

    task automatic checkLayer(string name, layerT exp, layerT act);
        checkCount++;
        if (act !== exp) begin
            $display("Error %s: layer expected %s, actual %s (%0d)", name, exp.name(),
                     act.name(), act);
            abortRun();
        end
    endtask

    task automatic checkAddr(string name, spriteAddrT exp, spriteAddrT act);
        checkCount++;
        if (act !== exp) begin
            $display("Error %s: address expected %0d, actual %0d", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkPos(string name, posT exp);
        checkCount++;
        if (playerX !== exp.x || playerY !== exp.y || playerDir !== exp.dir) begin
            $display("Error %s: position expected (%0d,%0d) dir %0d, actual (%0d,%0d) dir %0d",
                     name, exp.x, exp.y, exp.dir, playerX, playerY, playerDir);
            abortRun();
        end
    endtask

    always @(posedge Clk) begin
        if (!rstN) begin
            expShow <= 1'b0;
        end else begin
            expShow <= (keycode == KeySpace);  // One clock behind the key
        end
    end

    // Expected result moves with the DUT output register
    always @(posedge Clk) begin
        expRes   <= stageRes;
        expValid <= stageValid && rstN;
        expName  <= stageName;
    end

    always @(negedge Clk) begin
        if (expValid) begin
            checkLayer(expName, expRes.layer, layer);
            checkAddr(expName, expRes.addr, spriteAddr);
        end
    end

    // Frames with key held, position checked around each tick and at frame end
    task automatic runFrames(string name, keycodeT key, int count);
        for (int i = 0; i < count; i++) begin
            @(negedge Clk);
            keycode  = key;
            frameClk = 1'b1;
            edgeCount++;
            repeat (TickLag) @(negedge Clk);
            checkPos(name, expPos);  // Tick pulse is high, nothing moved yet
            if (edgeCount % FrameDiv == 0) begin
                expPos = nextPos(expPos, key);
            end
            @(negedge Clk);
            checkPos(name, expPos);
            repeat (FrameHigh - TickLag - 1) @(negedge Clk);
            frameClk = 1'b0;
            repeat (FrameLow) @(negedge Clk);
            checkPos(name, expPos);
        end
    endtask

    task automatic runPixels(string name, int x0, int y0, int w, int h, int count);
        int px;
        int py;
        for (int i = 0; i < count; i++) begin
            @(negedge Clk);
            px         = x0 + int'($urandom_range(w - 1, 0));
            py         = y0 + int'($urandom_range(h - 1, 0));
            pixelX     = coordT'(px);
            pixelY     = coordT'(py);
            stageRes   = refPixel(px, py, expPos, expShow);
            stageValid = 1'b1;
            stageName  = name;
        end
        @(negedge Clk);
        stageValid = 1'b0;
    endtask

    // Face one way, probe with space held, then the attack box after release
    task automatic runAttack(string name, keycodeT dirKey);
        runFrames(name, dirKey, FrameDiv);
        keycode = KeySpace;
        runPixels(name, int'(expPos.x) - 8, int'(expPos.y) - 8, 72, 80, 200);
        keycode = '0;
        runPixels({name, "Off"}, int'(expPos.x) + AttackDx[expPos.dir],
                  int'(expPos.y) + AttackDy[expPos.dir], AttackW, AttackH, 60);
    endtask

    task automatic runClamp(string name, keycodeT key);
        posT edgePos;
        runFrames(name, key, ClampFrames);
        edgePos = expPos;
        case (key)
            KeyD: edgePos.x = coordT'(MaxX);
            KeyA: edgePos.x = '0;
            KeyW: edgePos.y = '0;
            default: edgePos.y = coordT'(MaxY);
        endcase
        checkPos({name, "Edge"}, edgePos);
    endtask

    initial begin
        #(TimeoutNs);
        $display("Timeout: run did not finish within %0d ns", TimeoutNs);
        abortRun();
    end

    initial begin
        void'($urandom(32'hf731c545));
        rstN       = 1'b0;
        frameClk   = 1'b0;
        keycode    = '0;
        pixelX     = '0;
        pixelY     = '0;
        stageRes   = '0;
        stageValid = 1'b0;
        stageName  = "reset";
        edgeCount  = 0;
        checkCount = 0;
        expPos.x   = StartX;
        expPos.y   = StartY;
        expPos.dir = DirDown;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;

        checkPos("reset", expPos);
        runPixels("resetBg", 0, 0, 100, 240, 60);  // Left of the player
        runFrames("moveRight", KeyD, MoveFrames);
        runFrames("moveLeft", KeyA, MoveFrames);
        runFrames("moveUp", KeyW, MoveFrames);
        runFrames("moveDown", KeyS, MoveFrames);
        runFrames("otherKey", 8'h05, FrameDiv);
        runPixels("player", int'(expPos.x) - 16, int'(expPos.y) - 16, 64, 80, 400);
        runAttack("attackDown", KeyS);
        runAttack("attackLeft", KeyA);
        runAttack("attackUp", KeyW);
        runAttack("attackRight", KeyD);
        runClamp("clampRight", KeyD);
        runClamp("clampLeft", KeyA);
        runClamp("clampUp", KeyW);
        runClamp("clampDown", KeyS);

        if (checkCount > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("No checks were run");
            abortRun();
        end
    end

endmodule

// File: gameCore.f
hdl/gamePkg.sv
hdl/frameTick.sv
hdl/playerMotion.sv
hdl/attackSprite.sv
hdl/spriteMixer.sv
hdl/gameCore.sv
verif/gameCore_checker.sv
verif/gameCoreTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the gameCore testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gameCoreTb \
    -f gameCore.f -o simGameCore > build.log 2>&1 \
    || { cat build.log; echo "Build failed, see build.log"; exit 1; }

./obj_dir/simGameCore > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
